/* verilog/apr_defines.svh */
`ifndef APR_DEFINES_SVH
`define APR_DEFINES_SVH

// Event flags and their home on the I/O bus slice
`define APR_NUM_FLAGS 8
`define APR_FLAG_BASE 6

// Bus slice, bit 0 is the most significant
`define APR_WORD_BITS 18

// Field widths
`define APR_BLOCK_BITS 3
`define APR_AC_BITS 4
`define APR_COMP_BITS 4
`define APR_MAGIC_BITS 9
`define APR_DIAG_SEL_BITS 3

// Bus positions of the multi-bit fields
`define APR_CUR_BLOCK_POS 6
`define APR_PREV_BLOCK_POS 9
`define APR_COMP_POS 9
`define APR_FM_ADR_POS 9
`define APR_EBOX_ERR_POS 12
`define APR_INT_POS 14

`endif

/* verilog/aprPkg.sv */
`include "apr_defines.svh"

package aprPkg;

  // One bit per event flag, index 0 sits at the flag base bit
  typedef logic [0:`APR_NUM_FLAGS-1] flagVecT;

  typedef enum logic [2:0] {
    flgSbusErr,
    flgNxmErr,
    flgIoPfErr,
    flgMbParErr,
    flgCDirParErr,
    flgSAdrParErr,
    flgPwrFail,
    flgSweepDone
  } flagIdxT;

  typedef logic [0:`APR_BLOCK_BITS-1] blockT;
  typedef logic [0:`APR_AC_BITS-1] acT;
  typedef logic [0:`APR_WORD_BITS-1] busWordT;

  // Fast-memory address source, coded as in the microcode FMADR field
  typedef enum logic [2:0] {
    srcAc      = 3'd0,
    srcAcPlus1 = 3'd1,
    srcXr      = 3'd2,
    srcVma     = 3'd3,
    srcAcPlus2 = 3'd4,
    srcAcPlus3 = 3'd5,
    srcAcMagic = 3'd6,
    srcMagic   = 3'd7
  } fmSrcT;

  typedef struct packed {
    flagVecT flags;
    flagVecT intEn;
    logic    interrupt;
    logic    anyEboxErr;
  } aprStatusT;

endpackage

/* verilog/cpuBusIf.sv */
`timescale 1ns/1ps

interface cpuBusIf import aprPkg::*; ();

  busWordT data;

  // Conditions-out strobes to the flag register
  logic selEn;
  logic selDis;
  logic selSet;
  logic selClr;

  logic loadAcBlocks;
  logic dataoApr;

  modport flagSide (
    input data,
    input selEn,
    input selDis,
    input selSet,
    input selClr
  );

  modport blockSide (
    input data,
    input loadAcBlocks
  );

  modport diagSide (
    input data,
    input dataoApr
  );

endinterface

/* verilog/aprFlags.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module aprFlags import aprPkg::*; (
  input  logic      clk,
  input  logic      rst,
  cpuBusIf.flagSide bus,
  input  flagVecT   events,
  input  logic      sweepBusy,
  output aprStatusT status
);

  flagVecT mask;
  flagVecT evVec;
  flagVecT flags;
  flagVecT flagsNext;
  flagVecT intEn;
  flagVecT intEnNext;
  logic    sweepBusyPrev;
  logic    anyEboxErr;

  assign mask = bus.data[`APR_FLAG_BASE +: `APR_NUM_FLAGS];

  // Sweep done comes from the end of a cache sweep, not from a pin
  always_comb begin
    evVec = events;
    evVec[flgSweepDone] = sweepBusyPrev & ~sweepBusy;
  end

  // Events are ORed in last so they beat a clear in the same cycle
  always_comb begin
    flagsNext = flags;
    if (bus.selClr) begin
      flagsNext = flagsNext & ~mask;
    end
    if (bus.selSet) begin
      flagsNext = flagsNext | mask;
    end
    flagsNext = flagsNext | evVec;
  end

  always_comb begin
    intEnNext = intEn;
    if (bus.selEn) begin
      intEnNext = intEn | mask;
    end else if (bus.selDis) begin
      intEnNext = intEn & ~mask;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= '0;
      intEn <= '0;
      sweepBusyPrev <= 1'b0;
      anyEboxErr <= 1'b0;
    end else begin
      flags <= flagsNext;
      intEn <= intEnNext;
      sweepBusyPrev <= sweepBusy;
      // Summary tracks the flags in the same cycle
      anyEboxErr <= flagsNext[flgNxmErr] | flagsNext[flgMbParErr] |
                    flagsNext[flgSAdrParErr];
    end
  end

  assign status = '{
    flags:      flags,
    intEn:      intEn,
    interrupt:  |(flags & intEn),
    anyEboxErr: anyEboxErr
  };

  enDisExclusive: assert property (
    @(posedge clk) disable iff (rst) !(bus.selEn && bus.selDis)
  ) else $error("selEn and selDis strobed together");

  eventSticks: assert property (
    @(posedge clk) disable iff (rst)
    (evVec != '0) |=> ((flags & $past(evVec)) == $past(evVec))
  ) else $error("event flag not set after its event");

endmodule

/* verilog/acBlocks.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module acBlocks import aprPkg::*; (
  input  logic       clk,
  input  logic       rst,
  cpuBusIf.blockSide bus,
  input  logic       xrPrevious,
  input  logic       vmaPrevEn,
  input  logic       loadVmaContext,
  output blockT      currentBlock,
  output blockT      prevBlock,
  output blockT      vmaBlock,
  output blockT      xrBlock
);

  blockT vmaBlockNext;

  // Previous context is used by PXCT style references
  assign vmaBlockNext = vmaPrevEn ? prevBlock : currentBlock;

  always_ff @(posedge clk) begin
    if (rst) begin
      currentBlock <= '0;
      prevBlock <= '0;
      vmaBlock <= '0;
    end else begin
      if (bus.loadAcBlocks) begin
        currentBlock <= bus.data[`APR_CUR_BLOCK_POS +: `APR_BLOCK_BITS];
        prevBlock <= bus.data[`APR_PREV_BLOCK_POS +: `APR_BLOCK_BITS];
      end
      // Captures the old blocks when both loads hit together
      if (loadVmaContext) begin
        vmaBlock <= vmaBlockNext;
      end
    end
  end

  // Index register fetch follows the same context choice
  assign xrBlock = xrPrevious ? prevBlock : currentBlock;

endmodule

/* verilog/fmAddress.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module fmAddress import aprPkg::*; (
  input  acT                           ac,
  input  acT                           xr,
  input  acT                           vmaLow,
  input  logic [0:`APR_MAGIC_BITS-1]   magic,
  input  fmSrcT                        fmSrc,
  input  blockT                        currentBlock,
  input  blockT                        xrBlock,
  input  blockT                        vmaBlock,
  output acT                           fmAdr,
  output blockT                        fmBlock
);

  acT    magicAc;
  blockT magicBlock;
  acT    acOffset;
  acT    acSum;

  assign magicAc = magic[5:8];
  assign magicBlock = magic[2:4];

  // One adder serves all the AC-relative sources
  always_comb begin
    acOffset = '0;
    case (fmSrc)
      srcAcPlus1: acOffset = acT'(1);
      srcAcPlus2: acOffset = acT'(2);
      srcAcPlus3: acOffset = acT'(3);
      srcAcMagic: acOffset = magicAc;
      default:    acOffset = '0;
    endcase
  end

  // Wraps within the 16-word block
  assign acSum = ac + acOffset;

  always_comb begin
    case (fmSrc)
      srcXr:    fmAdr = xr;
      srcVma:   fmAdr = vmaLow;
      srcMagic: fmAdr = magicAc;
      default:  fmAdr = acSum;
    endcase
  end

  always_comb begin
    case (fmSrc)
      srcXr:    fmBlock = xrBlock;
      srcVma:   fmBlock = vmaBlock;
      // Literal addressing reaches any block
      srcMagic: fmBlock = magicBlock;
      default:  fmBlock = currentBlock;
    endcase
  end

endmodule

/* verilog/aprDiag.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module aprDiag import aprPkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  cpuBusIf.diagSide                     bus,
  input  logic                          diagRead,
  input  logic [`APR_DIAG_SEL_BITS-1:0] diagSel,
  input  aprStatusT                     status,
  input  blockT                         currentBlock,
  input  blockT                         prevBlock,
  input  blockT                         vmaBlock,
  input  acT                            fmAdr,
  input  blockT                         fmBlock,
  output busWordT                       diagData,
  output logic                          diagValid
);

  // Fetch, read, write, user
  logic [0:`APR_COMP_BITS-1] compareBits;
  busWordT                   diagWord;

  always_ff @(posedge clk) begin
    if (rst) begin
      compareBits <= '0;
    end else if (bus.dataoApr) begin
      compareBits <= bus.data[`APR_COMP_POS +: `APR_COMP_BITS];
    end
  end

  always_comb begin
    diagWord = '0;
    case (diagSel)
      3'd0: begin
        diagWord[`APR_FLAG_BASE +: `APR_NUM_FLAGS] = status.flags;
        diagWord[`APR_INT_POS] = status.interrupt;
      end
      3'd1: begin
        diagWord[`APR_FLAG_BASE +: `APR_NUM_FLAGS] = status.intEn;
      end
      3'd2: begin
        diagWord[`APR_CUR_BLOCK_POS +: `APR_BLOCK_BITS] = currentBlock;
        diagWord[`APR_PREV_BLOCK_POS +: `APR_BLOCK_BITS] = prevBlock;
      end
      3'd3: begin
        diagWord[`APR_COMP_POS +: `APR_COMP_BITS] = compareBits;
      end
      3'd4: begin
        diagWord[`APR_CUR_BLOCK_POS +: `APR_BLOCK_BITS] = fmBlock;
        diagWord[`APR_FM_ADR_POS +: `APR_AC_BITS] = fmAdr;
      end
      3'd5: begin
        diagWord[`APR_CUR_BLOCK_POS +: `APR_BLOCK_BITS] = vmaBlock;
        diagWord[`APR_EBOX_ERR_POS] = status.anyEboxErr;
      end
      // Unused selects read as zero
      default: diagWord = '0;
    endcase
  end

  // Every read gets its own word, back to back reads included
  always_ff @(posedge clk) begin
    if (rst) begin
      diagData <= '0;
      diagValid <= 1'b0;
    end else begin
      diagValid <= diagRead;
      if (diagRead) begin
        diagData <= diagWord;
      end
    end
  end

  validOnlyOnRead: assert property (
    @(posedge clk) disable iff (rst)
    (diagValid && $past(diagValid)) |-> ($past(diagRead) && $past(diagRead, 2))
  ) else $error("diagValid held without back to back reads");

endmodule

/* verilog/aprTop.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module aprTop import aprPkg::*; (
  input  logic                          clk,
  input  logic                          rst,
  input  busWordT                       busData,
  input  logic                          selEn,
  input  logic                          selDis,
  input  logic                          selSet,
  input  logic                          selClr,
  input  logic                          loadAcBlocks,
  input  logic                          dataoApr,
  input  flagVecT                       events,
  input  logic                          sweepBusy,
  input  logic                          xrPrevious,
  input  logic                          vmaPrevEn,
  input  logic                          loadVmaContext,
  input  acT                            ac,
  input  acT                            xr,
  input  acT                            vmaLow,
  input  logic [0:`APR_MAGIC_BITS-1]    magic,
  input  fmSrcT                         fmSrc,
  input  logic                          diagRead,
  input  logic [`APR_DIAG_SEL_BITS-1:0] diagSel,
  output logic                          aprInterrupt,
  output logic                          anyEboxErr,
  output acT                            fmAdr,
  output blockT                         fmBlock,
  output busWordT                       diagData,
  output logic                          diagValid
);

  aprStatusT status;
  blockT     currentBlock;
  blockT     prevBlock;
  blockT     vmaBlock;
  blockT     xrBlock;

  cpuBusIf bus ();

  assign bus.data = busData;
  assign bus.selEn = selEn;
  assign bus.selDis = selDis;
  assign bus.selSet = selSet;
  assign bus.selClr = selClr;
  assign bus.loadAcBlocks = loadAcBlocks;
  assign bus.dataoApr = dataoApr;

  aprFlags flags0 (
    .clk       (clk),
    .rst       (rst),
    .bus       (bus.flagSide),
    .events    (events),
    .sweepBusy (sweepBusy),
    .status    (status)
  );

  acBlocks blocks0 (
    .clk            (clk),
    .rst            (rst),
    .bus            (bus.blockSide),
    .xrPrevious     (xrPrevious),
    .vmaPrevEn      (vmaPrevEn),
    .loadVmaContext (loadVmaContext),
    .currentBlock   (currentBlock),
    .prevBlock      (prevBlock),
    .vmaBlock       (vmaBlock),
    .xrBlock        (xrBlock)
  );

  fmAddress fmAdr0 (
    .ac           (ac),
    .xr           (xr),
    .vmaLow       (vmaLow),
    .magic        (magic),
    .fmSrc        (fmSrc),
    .currentBlock (currentBlock),
    .xrBlock      (xrBlock),
    .vmaBlock     (vmaBlock),
    .fmAdr        (fmAdr),
    .fmBlock      (fmBlock)
  );

  aprDiag diag0 (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus.diagSide),
    .diagRead     (diagRead),
    .diagSel      (diagSel),
    .status       (status),
    .currentBlock (currentBlock),
    .prevBlock    (prevBlock),
    .vmaBlock     (vmaBlock),
    .fmAdr        (fmAdr),
    .fmBlock      (fmBlock),
    .diagData     (diagData),
    .diagValid    (diagValid)
  );

  assign aprInterrupt = status.interrupt;
  assign anyEboxErr = status.anyEboxErr;

endmodule

/* bench/aprTb.sv */
`timescale 1ns/1ps
`include "apr_defines.svh"

module aprTb import aprPkg::*; ();

  localparam int flagCycles = 300;
  localparam int intCycles = 300;
  localparam int sweepCycles = 200;
  localparam int blockCycles = 300;
  localparam int adrCycles = 240;
  localparam int compCycles = 80;
  // Each test adds two idle cycles, plus the initial reset
  localparam int totalCycles = flagCycles + intCycles + sweepCycles + blockCycles +
                               adrCycles + compCycles + 6 * 2 + 3;
  localparam int limitNs = totalCycles * 8 + 400;

  logic       clk;
  logic       rst;
  busWordT    busData;
  logic       selEn;
  logic       selDis;
  logic       selSet;
  logic       selClr;
  logic       loadAcBlocks;
  logic       dataoApr;
  flagVecT    events;
  logic       sweepBusy;
  logic       xrPrevious;
  logic       vmaPrevEn;
  logic       loadVmaContext;
  acT         ac;
  acT         xr;
  acT         vmaLow;
  logic [0:8] magic;
  fmSrcT      fmSrc;
  logic       diagRead;
  logic [2:0] diagSel;
  logic       aprInterrupt;
  logic       anyEboxErr;
  acT         fmAdr;
  blockT      fmBlock;
  busWordT    diagData;
  logic       diagValid;

  // Reference model state
  flagVecT    refFlags;
  flagVecT    refIntEn;
  flagVecT    refFlagsNext;
  flagVecT    refEvents;
  flagVecT    busMask;
  logic       refEbox;
  logic       refSweepPrev;
  logic       refInt;
  blockT      refCur;
  blockT      refPrev;
  blockT      refVma;
  blockT      refXrBlock;
  logic [0:3] refCompare;
  acT         refAdr;
  blockT      refBlock;
  busWordT    refData;
  logic       refValid;

  logic [31:0] lcgState = 32'h472f;
  int          errors = 0;
  int          passCount = 0;
  int          failCount = 0;

  aprTop dut0 (.*);

  always #4 clk = ~clk;

  // Upper halves only, the low LCG bits repeat too quickly
  function automatic logic [31:0] nextRand();
    logic [15:0] hi;
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    hi = lcgState[31:16];
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return {hi, lcgState[31:16]};
  endfunction

  always_comb begin
    busMask = busData[`APR_FLAG_BASE +: 8];
    refEvents = events;
    refEvents[7] = refSweepPrev && !sweepBusy;
    for (int i = 0; i < 8; i++) begin
      refFlagsNext[i] = refEvents[i] || (selSet && busMask[i]) ||
                        (refFlags[i] && !(selClr && busMask[i]));
    end
    refInt = |(refFlags & refIntEn);
    refXrBlock = xrPrevious ? refPrev : refCur;
    case (fmSrc)
      srcAc:      refAdr = ac;
      srcAcPlus1: refAdr = ac + 4'd1;
      srcAcPlus2: refAdr = ac + 4'd2;
      srcAcPlus3: refAdr = ac + 4'd3;
      srcAcMagic: refAdr = ac + magic[5:8];
      srcXr:      refAdr = xr;
      srcVma:     refAdr = vmaLow;
      default:    refAdr = magic[5:8];
    endcase
    case (fmSrc)
      srcXr:    refBlock = refXrBlock;
      srcVma:   refBlock = refVma;
      srcMagic: refBlock = magic[2:4];
      default:  refBlock = refCur;
    endcase
  end

  function automatic busWordT expWord(logic [2:0] sel);
    busWordT w;
    w = '0;
    case (sel)
      3'd0: begin
        w[`APR_FLAG_BASE +: 8] = refFlags;
        w[14] = refInt;
      end
      3'd1: w[`APR_FLAG_BASE +: 8] = refIntEn;
      3'd2: begin
        w[6:8] = refCur;
        w[9:11] = refPrev;
      end
      3'd3: w[9:12] = refCompare;
      3'd4: begin
        w[6:8] = refBlock;
        w[9:12] = refAdr;
      end
      3'd5: begin
        w[6:8] = refVma;
        w[12] = refEbox;
      end
      default: w = '0;
    endcase
    return w;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      refFlags <= '0;
      refIntEn <= '0;
      refEbox <= 1'b0;
      refSweepPrev <= 1'b0;
      refCur <= '0;
      refPrev <= '0;
      refVma <= '0;
      refCompare <= '0;
      refData <= '0;
      refValid <= 1'b0;
    end else begin
      refFlags <= refFlagsNext;
      if (selEn) begin
        refIntEn <= refIntEn | busMask;
      end else if (selDis) begin
        refIntEn <= refIntEn & ~busMask;
      end
      // nxm, mbPar and sAdrPar
      refEbox <= refFlagsNext[1] | refFlagsNext[3] | refFlagsNext[5];
      refSweepPrev <= sweepBusy;
      if (loadAcBlocks) begin
        refCur <= busData[6:8];
        refPrev <= busData[9:11];
      end
      if (loadVmaContext) begin
        refVma <= vmaPrevEn ? refPrev : refCur;
      end
      if (dataoApr) begin
        refCompare <= busData[9:12];
      end
      refValid <= diagRead;
      if (diagRead) begin
        refData <= expWord(diagSel);
      end
    end
  end

  intCheck: assert property (@(posedge clk) disable iff (rst) aprInterrupt == refInt)
    else begin
      errors++;
      $display("mismatch at %0t: aprInterrupt got %b expected %b", $time,
               $sampled(aprInterrupt), $sampled(refInt));
    end

  eboxCheck: assert property (@(posedge clk) disable iff (rst) anyEboxErr == refEbox)
    else begin
      errors++;
      $display("mismatch at %0t: anyEboxErr got %b expected %b", $time,
               $sampled(anyEboxErr), $sampled(refEbox));
    end

  adrCheck: assert property (@(posedge clk) disable iff (rst) fmAdr == refAdr)
    else begin
      errors++;
      $display("mismatch at %0t: fmAdr got %h expected %h", $time,
               $sampled(fmAdr), $sampled(refAdr));
    end

  blockCheck: assert property (@(posedge clk) disable iff (rst) fmBlock == refBlock)
    else begin
      errors++;
      $display("mismatch at %0t: fmBlock got %h expected %h", $time,
               $sampled(fmBlock), $sampled(refBlock));
    end

  validCheck: assert property (@(posedge clk) disable iff (rst) diagValid == refValid)
    else begin
      errors++;
      $display("mismatch at %0t: diagValid got %b expected %b", $time,
               $sampled(diagValid), $sampled(refValid));
    end

  dataCheck: assert property (@(posedge clk) disable iff (rst)
    diagValid |-> diagData == refData)
    else begin
      errors++;
      $display("mismatch at %0t: diagData got %h expected %h", $time,
               $sampled(diagData), $sampled(refData));
    end

  resetCheck: assert property (@(posedge clk)
    $fell(rst) |-> (!aprInterrupt && !diagValid && diagData == '0))
    else begin
      errors++;
      $display("outputs were not cleared when reset was released at %0t", $time);
    end

  task automatic idleInputs();
    rst = 1'b0;
    selEn = 1'b0;
    selDis = 1'b0;
    selSet = 1'b0;
    selClr = 1'b0;
    loadAcBlocks = 1'b0;
    loadVmaContext = 1'b0;
    dataoApr = 1'b0;
    events = '0;
    diagRead = 1'b0;
  endtask

  task automatic runTest(input string name, input int mode, input int cycles);
    int          errBefore;
    logic [31:0] r;
    logic [31:0] r2;
    errBefore = errors;
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      r = nextRand();
      r2 = nextRand();
      idleInputs();
      busData = r2[17:0];
      case (mode)
        1: begin
          selSet = (r[1:0] == 2'd1);
          selClr = (r[1:0] == 2'd2);
          events = flagVecT'(r[15:8] & r[23:16]);
          diagRead = r[4];
          diagSel = 3'd0;
        end
        2: begin
          selEn = (r[1:0] == 2'd1);
          selDis = (r[1:0] == 2'd2);
          selClr = (r[2:0] == 3'd3);
          events = flagVecT'(r[15:8] & r[23:16] & r[31:24]);
          diagRead = r[4];
          diagSel = {2'b00, r[5]};
        end
        3: begin
          if (r[3:0] < 4'd3) begin
            sweepBusy = !sweepBusy;
          end
          // Only the nxm, mbPar and sAdrPar events
          events = flagVecT'(r[15:8] & r[23:16] & 8'h54);
          selClr = r[6] & r[7];
          diagRead = r[4];
          diagSel = r[5] ? 3'd5 : 3'd0;
        end
        4: begin
          loadAcBlocks = r[0] & r[1];
          loadVmaContext = r[2];
          vmaPrevEn = r[3];
          diagRead = r[4];
          diagSel = r[5] ? 3'd2 : 3'd5;
        end
        5: begin
          fmSrc = fmSrcT'(i[2:0]);
          ac = r[3:0];
          xr = r[7:4];
          vmaLow = r[11:8];
          magic = r[20:12];
          xrPrevious = r[21];
          loadAcBlocks = r[22] & r[23];
          loadVmaContext = r[24];
          vmaPrevEn = r[25];
          diagRead = r[26];
          diagSel = 3'd4;
        end
        default: begin
          if (i >= 30 && i < 33) begin
            rst = 1'b1;
          end else if (i >= 33 && i < 41) begin
            // Read every select straight after reset
            diagRead = 1'b1;
            diagSel = 3'(i - 33);
          end else begin
            dataoApr = r[0];
            selSet = r[1];
            selEn = r[2];
            loadAcBlocks = r[3];
            diagRead = r[4];
            diagSel = r[7:5];
          end
        end
      endcase
    end
    @(negedge clk);
    idleInputs();
    @(negedge clk);
    if (errors == errBefore) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d errors", name, errors - errBefore);
    end
  endtask

  initial begin
    clk = 1'b0;
    idleInputs();
    rst = 1'b1;
    busData = '0;
    sweepBusy = 1'b0;
    xrPrevious = 1'b0;
    vmaPrevEn = 1'b0;
    ac = '0;
    xr = '0;
    vmaLow = '0;
    magic = '0;
    fmSrc = srcAc;
    diagSel = 3'd0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    runTest("flag rules", 1, flagCycles);
    runTest("interrupt", 2, intCycles);
    runTest("sweep done", 3, sweepCycles);
    runTest("block registers", 4, blockCycles);
    runTest("address generation", 5, adrCycles);
    runTest("compare and reset", 6, compCycles);
    $display("tests passed %0d failed %0d, errors %0d", passCount, failCount, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(limitNs);
    $display("timeout: the tests did not finish within %0d ns", limitNs);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+verilog
verilog/aprPkg.sv
verilog/cpuBusIf.sv
verilog/aprFlags.sv
verilog/acBlocks.sv
verilog/fmAddress.sv
verilog/aprDiag.sv
verilog/aprTop.sv
bench/aprTb.sv

/* run.sh */
#!/bin/sh
# Build and run the APR status block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module aprTb --Mdir obj_dir -o aprSim

simOut=$(./obj_dir/aprSim)
echo "$simOut"

if echo "$simOut" | grep -qx "RESULT: PASS"; then
  exit 0
fi
exit 1
